// ==== filelist.f ====
pkt_pkg.sv
pkt_stream_if.sv
pkt_fifo.sv
pkt_merge.sv
pkt_merge_top.sv
tb_pkt_merge.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_pkt_merge
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = CHECKS FAILED
PASS_MSG  = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_pkt_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_pkt_merge;

    localparam int TIMEOUT_CYCLES = 20000;   // tests need under 2000 cycles together

    logic                       clk;
    logic                       rst;
    logic [1:0]                 in_clk;
    logic [1:0]                 wr_sop;
    logic [1:0]                 wr_eop;
    logic [1:0]                 wr_vld;
    logic [pkt_pkg::DATA_W-1:0] wr_data [2];
    logic                       overflow_0;
    logic                       overflow_1;
    logic                       out_ready;
    logic                       out_sop;
    logic                       out_eop;
    logic                       out_vld;
    logic                       out_port;
    logic [pkt_pkg::DATA_W-1:0] out_data;

    // reference model, one queue per port
    pkt_pkg::entry_t q0 [$];
    pkt_pkg::entry_t q1 [$];
    logic [1:0] in_pkt_m;
    logic [1:0] ovf_m;
    logic       last_srv;     // port of the last word seen at the output
    logic       pkt_open;
    logic       open_port;
    logic       rand_ready;
    logic       rr_mode;
    int         rr_pkts;
    int         n_checks;
    int         errors;
    int         test_err0;
    int         cycles;

    pkt_merge_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .in_clk_0   (in_clk[0]),
        .wr_sop_0   (wr_sop[0]),
        .wr_eop_0   (wr_eop[0]),
        .wr_vld_0   (wr_vld[0]),
        .wr_data_0  (wr_data[0]),
        .overflow_0 (overflow_0),
        .in_clk_1   (in_clk[1]),
        .wr_sop_1   (wr_sop[1]),
        .wr_eop_1   (wr_eop[1]),
        .wr_vld_1   (wr_vld[1]),
        .wr_data_1  (wr_data[1]),
        .overflow_1 (overflow_1),
        .out_ready  (out_ready),
        .out_sop    (out_sop),
        .out_eop    (out_eop),
        .out_vld    (out_vld),
        .out_data   (out_data),
        .out_port   (out_port)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d clock cycles", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // random sink back-pressure
    always begin
        @(posedge clk);
        #1;
        if (rand_ready) begin
            out_ready = ($urandom_range(99, 0) < 70);   // about 70 % high
        end
    end

    function automatic int model_size(input logic p);
        return p ? q1.size() : q0.size();
    endfunction

    function automatic pkt_pkg::entry_t model_pop(input logic p);
        if (p) begin
            return q1.pop_front();
        end
        return q0.pop_front();
    endfunction

    // framing filter and full rule as the source sees them
    function automatic void model_write(input logic p, input logic s, input logic e,
                                        input logic v, input logic [pkt_pkg::DATA_W-1:0] d);
        pkt_pkg::entry_t ent;
        if (v && (s || in_pkt_m[p])) begin
            if (model_size(p) == pkt_pkg::FIFO_DEPTH) begin
                ovf_m[p] = 1'b1;
            end else begin
                ent = '{sop: s, eop: e, vld: v, data: d};
                if (p) q1.push_back(ent);
                else q0.push_back(ent);
            end
            in_pkt_m[p] = ~e;
        end
    endfunction

    function automatic void clear_model();
        q0.delete();
        q1.delete();
        in_pkt_m = '0;
        ovf_m    = '0;
        last_srv = 1'b1;      // port 0 wins the first tie
        pkt_open = 1'b0;
    endfunction

    // output monitor, mid-cycle so inputs and outputs have settled
    always @(negedge clk) begin : monitor
        pkt_pkg::entry_t exp_e;
        if (!rst && out_vld && out_ready) begin
            n_checks++;
            assert (model_size(out_port) != 0) else begin
                $display("ERR %0t: word on port %0d with nothing expected", $time, out_port);
                errors++;
            end
            if (model_size(out_port) != 0) begin
                exp_e = model_pop(out_port);
                assert (out_sop == exp_e.sop && out_eop == exp_e.eop && out_data == exp_e.data)
                else begin
                    $display("ERR %0t: port %0d got sop %b eop %b data %h, expected %b %b %h",
                             $time, out_port, out_sop, out_eop, out_data,
                             exp_e.sop, exp_e.eop, exp_e.data);
                    errors++;
                end
            end
            assert (!pkt_open || out_port == open_port) else begin
                $display("ERR %0t: port switched to %0d inside a packet", $time, out_port);
                errors++;
            end
            if (out_sop && rr_mode) begin
                rr_pkts++;
                assert (out_port == !last_srv) else begin
                    $display("ERR %0t: packet from port %0d out of turn", $time, out_port);
                    errors++;
                end
            end
            if (out_sop) begin
                pkt_open  = 1'b1;
                open_port = out_port;
            end
            if (out_eop) pkt_open = 1'b0;
            last_srv = out_port;
        end
    end

    // one word per strobe period, changed while the strobe is low
    task automatic send_word(input logic p, input logic s, input logic e, input logic v,
                             input logic [pkt_pkg::DATA_W-1:0] d);
        wr_sop[p]  = s;
        wr_eop[p]  = e;
        wr_vld[p]  = v;
        wr_data[p] = d;
        model_write(p, s, e, v, d);
        repeat (4) @(posedge clk);
        #1 in_clk[p] = 1'b1;
        repeat (4) @(posedge clk);     // write lands on the last of these edges
        #1 in_clk[p] = 1'b0;
    endtask

    task automatic send_packet(input logic p, input int len);
        logic [31:0] r;
        for (int i = 0; i < len; i++) begin
            r = $urandom;
            send_word(p, i == 0, i == len - 1, 1'b1, r[pkt_pkg::DATA_W-1:0]);
        end
    endtask

    task automatic send_random_packets(input logic p, input int n);
        for (int k = 0; k < n; k++) begin
            send_packet(p, $urandom_range(6, 1));
        end
    endtask

    task automatic wait_drain();
        while (q0.size() != 0 || q1.size() != 0) begin
            @(posedge clk);
        end
        repeat (16) @(posedge clk);    // room for a stray extra word to show up
        #1;
    endtask

    task automatic reset_dut();
        rst = 1'b1;
        clear_model();
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    task automatic check_idle();
        n_checks++;
        assert (!out_vld && !out_sop && !out_eop && out_data == '0 && !out_port) else begin
            $display("ERR %0t: outputs not idle after reset, vld %b data %h port %0d",
                     $time, out_vld, out_data, out_port);
            errors++;
        end
        n_checks++;
        assert (!overflow_0 && !overflow_1) else begin
            $display("ERR %0t: overflow flags %b %b after reset", $time, overflow_0, overflow_1);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-10s %s, %0d errors", name, (errors == test_err0) ? "ok" : "failed",
                 errors - test_err0);
        test_err0 = errors;
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        in_clk     = '0;
        wr_sop     = '0;
        wr_eop     = '0;
        wr_vld     = '0;
        wr_data[0] = '0;
        wr_data[1] = '0;
        out_ready  = 1'b0;
        rand_ready = 1'b0;
        rr_mode    = 1'b0;
        rr_pkts    = 0;
        n_checks   = 0;
        errors     = 0;
        test_err0  = 0;
        cycles     = 0;
        void'($urandom(48081));
        reset_dut();

        out_ready = 1'b1;
        send_random_packets(1'b0, 8);
        wait_drain();
        end_test("single");

        // junk outside a packet on both ports, then real packets
        for (int k = 0; k < 3; k++) begin
            send_word(1'b0, 1'b0, 1'b0, 1'b1, 16'h0bad);
            send_word(1'b1, 1'b0, 1'b1, 1'b1, 16'h0e0f);    // stray eop
            send_word(1'b0, 1'b1, 1'b0, 1'b0, 16'h0000);    // sop without vld
        end
        send_random_packets(1'b0, 3);
        send_random_packets(1'b1, 2);
        wait_drain();
        end_test("framing");

        rand_ready = 1'b1;
        fork
            send_random_packets(1'b0, 6);
            send_random_packets(1'b1, 6);
        join
        wait_drain();
        rand_ready = 1'b0;
        out_ready  = 1'b1;
        end_test("atomic");

        reset_dut();
        out_ready = 1'b0;
        rr_mode   = 1'b1;
        rr_pkts   = 0;
        fork
            send_random_packets(1'b0, 3);
            send_random_packets(1'b1, 3);
        join
        repeat (4) @(posedge clk);     // both FIFOs hold their last words by now
        #1 out_ready = 1'b1;
        wait_drain();
        n_checks++;
        assert (rr_pkts == 6) else begin
            $display("ERR %0t: %0d packets seen in round-robin test, expected 6", $time, rr_pkts);
            errors++;
        end
        rr_mode = 1'b0;
        end_test("rr");

        out_ready = 1'b0;
        send_packet(1'b1, 40);
        repeat (2) @(posedge clk);
        #1;
        n_checks++;
        assert (overflow_1 == ovf_m[1] && overflow_0 == ovf_m[0]) else begin
            $display("ERR %0t: overflow %b %b, expected %b %b", $time,
                     overflow_0, overflow_1, ovf_m[0], ovf_m[1]);
            errors++;
        end
        out_ready = 1'b1;
        wait_drain();
        end_test("overflow");

        // open packet on port 0 cut off by reset
        out_ready = 1'b0;
        send_word(1'b0, 1'b1, 1'b0, 1'b1, 16'h1234);
        reset_dut();
        check_idle();
        out_ready = 1'b1;
        send_random_packets(1'b1, 2);
        wait_drain();
        end_test("reset");

        $display("summary: %0d checks, %0d errors", n_checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pkt_merge_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pkt_merge_top (
    input  logic                       clk,
    input  logic                       rst,

    // port 0 source
    input  logic                       in_clk_0,
    input  logic                       wr_sop_0,
    input  logic                       wr_eop_0,
    input  logic                       wr_vld_0,
    input  logic [pkt_pkg::DATA_W-1:0] wr_data_0,
    output logic                       overflow_0,

    // port 1 source
    input  logic                       in_clk_1,
    input  logic                       wr_sop_1,
    input  logic                       wr_eop_1,
    input  logic                       wr_vld_1,
    input  logic [pkt_pkg::DATA_W-1:0] wr_data_1,
    output logic                       overflow_1,

    // merged stream
    input  logic                       out_ready,
    output logic                       out_sop,
    output logic                       out_eop,
    output logic                       out_vld,
    output logic [pkt_pkg::DATA_W-1:0] out_data,
    output logic                       out_port
);

    pkt_stream_if s0 ();    // FIFO 0 head
    pkt_stream_if s1 ();    // FIFO 1 head

    pkt_fifo u_fifo0 (
        .clk      (clk),
        .rst      (rst),
        .in_clk   (in_clk_0),
        .wr_sop   (wr_sop_0),
        .wr_eop   (wr_eop_0),
        .wr_vld   (wr_vld_0),
        .wr_data  (wr_data_0),
        .overflow (overflow_0),
        .rd       (s0.source)
    );

    pkt_fifo u_fifo1 (
        .clk      (clk),
        .rst      (rst),
        .in_clk   (in_clk_1),
        .wr_sop   (wr_sop_1),
        .wr_eop   (wr_eop_1),
        .wr_vld   (wr_vld_1),
        .wr_data  (wr_data_1),
        .overflow (overflow_1),
        .rd       (s1.source)
    );

    pkt_merge u_merge (
        .clk       (clk),
        .rst       (rst),
        .in0       (s0.sink),
        .in1       (s1.sink),
        .out_ready (out_ready),
        .out_sop   (out_sop),
        .out_eop   (out_eop),
        .out_vld   (out_vld),
        .out_port  (out_port),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// ==== pkt_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module pkt_merge (
    input  logic                       clk,
    input  logic                       rst,
    pkt_stream_if.sink                 in0,
    pkt_stream_if.sink                 in1,
    input  logic                       out_ready,
    output logic                       out_sop,
    output logic                       out_eop,
    output logic                       out_vld,
    output logic                       out_port,
    output logic [pkt_pkg::DATA_W-1:0] out_data
);

    pkt_pkg::entry_t head [pkt_pkg::NUM_PORTS];
    pkt_pkg::entry_t word;

    logic [pkt_pkg::NUM_PORTS-1:0] rdy;
    logic [pkt_pkg::NUM_PORTS-1:0] cand;   // ready with a packet start at the head
    logic [pkt_pkg::NUM_PORTS-1:0] pop;

    logic busy;      // packet open, locked on cur
    logic cur;
    logic last;      // port that sent the last word
    logic pick;
    logic sel;
    logic xfer;
    logic discard;
    logic dsel;

    assign head[0] = '{sop: in0.sop, eop: in0.eop, vld: in0.vld, data: in0.data};
    assign head[1] = '{sop: in1.sop, eop: in1.eop, vld: in1.vld, data: in1.data};

    assign rdy  = {in1.ready, in0.ready};
    assign cand = rdy & {head[1].sop & head[1].vld, head[0].sop & head[0].vld};

    // round robin between packet starts
    always_comb begin
        if (&cand) begin
            pick = ~last;          // both waiting, the other port's turn
        end else begin
            pick = cand[1];        // whichever one is there, else port 0
        end
    end

    assign sel  = busy ? cur : pick;
    assign word = head[sel];

    assign out_vld = busy ? rdy[cur] : |cand;
    assign xfer    = out_vld & out_ready;

    // headless word at an idle head, left over from a truncated packet
    assign discard = ~busy & ~|cand & |rdy;
    assign dsel    = ~rdy[0];      // port 0 first

    assign pop[0] = (xfer & ~sel) | (discard & ~dsel);
    assign pop[1] = (xfer & sel) | (discard & dsel);

    assign in0.next = pop[0];
    assign in1.next = pop[1];

    // output only shows a word while it is valid
    assign out_sop  = out_vld & word.sop;
    assign out_eop  = out_vld & word.eop;
    assign out_data = out_vld ? word.data : '0;
    assign out_port = sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cur  <= 1'b0;
            last <= 1'b1;          // so port 0 wins the first tie
        end else if (xfer) begin
            cur  <= sel;
            busy <= ~word.eop;     // lock until eop has gone out
            last <= sel;
        end
    end

    // valid output always comes from a FIFO that holds data
    a_vld_ready: assert property (
        @(posedge clk) disable iff (rst)
        out_vld |-> rdy[out_port]
    ) else $error("pkt_merge: out_vld without ready FIFO");

    // a packet stays on one port from sop to eop
    a_port_hold: assert property (
        @(posedge clk) disable iff (rst)
        (out_vld && out_ready && !out_eop) |=> $stable(out_port)
    ) else $error("pkt_merge: port changed inside a packet");

    // one pop per cycle at most
    a_one_next: assert property (
        @(posedge clk) disable iff (rst)
        !(in0.next && in1.next)
    ) else $error("pkt_merge: next on both ports");

endmodule

`default_nettype wire

// ==== pkt_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module pkt_fifo (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_clk,
    input  logic                       wr_sop,
    input  logic                       wr_eop,
    input  logic                       wr_vld,
    input  logic [pkt_pkg::DATA_W-1:0] wr_data,
    output logic                       overflow,
    pkt_stream_if.source               rd
);

    pkt_pkg::entry_t mem [pkt_pkg::FIFO_DEPTH];
    pkt_pkg::entry_t head;

    logic [pkt_pkg::PTR_W-1:0] wptr;
    logic [pkt_pkg::PTR_W-1:0] rptr;
    logic [pkt_pkg::CNT_W-1:0] count;

    logic [3:0] in_sync;    // three sync stages plus one for the edge
    logic       sample;
    logic       in_pkt;
    logic       accept;
    logic       full;
    logic       push;
    logic       pop;

    // source strobe into clk
    always_ff @(posedge clk) begin
        in_sync <= {in_sync[2:0], in_clk};
    end

    assign sample = in_sync[2] & ~in_sync[3];   // rising edge of in_clk

    // framing filter
    // a word counts if it opens a packet or lands inside one
    assign accept = sample & wr_vld & (wr_sop | in_pkt);

    assign full = (count == pkt_pkg::DEPTH_CNT);
    assign push = accept & ~full;
    assign pop  = rd.next & rd.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wptr     <= '0;
            rptr     <= '0;
            count    <= '0;
            in_pkt   <= 1'b0;
            overflow <= 1'b0;
        end else begin
            // framing follows the source even when the word is lost to full
            if (accept) begin
                in_pkt <= ~wr_eop;     // sop+eop in one word leaves us outside
            end

            if (push) begin
                wptr <= wptr + 1'b1;
            end
            if (pop) begin
                rptr <= rptr + 1'b1;
            end

            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end

            if (accept && full) begin
                overflow <= 1'b1;      // sticky until rst
            end
        end
    end

    // storage, flags written as received so a packet start keeps its sop
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wptr] <= '{sop: wr_sop, eop: wr_eop, vld: wr_vld, data: wr_data};
        end
    end

    assign head = mem[rptr];

    assign rd.ready = (count != '0);
    assign rd.sop   = head.sop;
    assign rd.eop   = head.eop;
    assign rd.vld   = head.vld;
    assign rd.data  = head.data;

    // merge must only pop a FIFO that holds data
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst)
        rd.next |-> (count != '0)
    ) else $error("pkt_fifo: pop while empty");

    // occupancy stays within the memory
    a_count_range: assert property (
        @(posedge clk) disable iff (rst)
        count <= pkt_pkg::DEPTH_CNT
    ) else $error("pkt_fifo: count above depth");

    // overflow only clears through rst
    a_overflow_sticky: assert property (
        @(posedge clk) disable iff (rst)
        overflow |=> overflow
    ) else $error("pkt_fifo: overflow fell without reset");

endmodule

`default_nettype wire

// ==== pkt_stream_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// head word of one packet FIFO and its pop strobe
interface pkt_stream_if;

    logic                        ready;  // FIFO holds at least one word
    logic                        sop;
    logic                        eop;
    logic                        vld;
    logic [pkt_pkg::DATA_W-1:0]  data;
    logic                        next;   // one-cycle pop, only while ready

    // FIFO side
    modport source (
        output ready,
        output sop,
        output eop,
        output vld,
        output data,
        input  next
    );

    // merge side
    modport sink (
        input  ready,
        input  sop,
        input  eop,
        input  vld,
        input  data,
        output next
    );

endinterface

`default_nettype wire

// ==== pkt_pkg.sv ====
`default_nettype none

package pkt_pkg;

    // payload and buffer sizing
    localparam int DATA_W     = 16;
    localparam int FIFO_DEPTH = 32;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);   // 5 for 32 entries
    localparam int NUM_PORTS  = 2;                   // merge is written for two

    // occupancy count needs one extra bit to hold FIFO_DEPTH itself
    localparam int CNT_W = PTR_W + 1;
    localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(FIFO_DEPTH);

    // one stored FIFO word, framing flags kept beside the data
    typedef struct packed {
        logic              sop;
        logic              eop;
        logic              vld;
        logic [DATA_W-1:0] data;
    } entry_t;

endpackage

`default_nettype wire
